// ==== source/img_geom_pkg.sv ====
// ------------------------------
// image window geometry
// window height, line memory count and column addressing
// ------------------------------

package img_geom_pkg;

        // ------------------------------
        // vertical window
        // ------------------------------
        localparam int win_rows   = 3;
        localparam int win_center = 1;
        localparam int win_pos_w  = $clog2(win_rows);

        // one memory per previous row
        localparam int line_count = win_rows - 1;
        localparam int line_sel_w = (line_count > 1) ? $clog2(line_count) : 1;

        typedef logic [line_sel_w-1:0] line_sel_t;

        // ------------------------------
        // columns
        // ------------------------------
        localparam int max_cols   = 64;
        localparam int mem_addr_w = $clog2(max_cols);

        // spare top bit so an overlong row becomes visible
        localparam int col_addr_w = mem_addr_w + 1;

        typedef logic [col_addr_w-1:0] col_addr_t;

endpackage

// ==== source/pixel_pkg.sv ====
// ------------------------------
// pixel payload types
// pixel, window column and raster flag bundle
// ------------------------------

package pixel_pkg;

        localparam int pixel_w = 8;

        typedef logic [pixel_w-1:0] pixel_t;

        // index 0 is the oldest row, top index the newest
        typedef pixel_t [img_geom_pkg::win_rows-1:0] window_t;

        // ------------------------------
        // raster markers
        // ------------------------------
        typedef struct packed {
                logic row_first;
                logic row_last;
                logic col_first;
                logic col_last;
                logic de;
        } img_flags_t;

        // all markers low
        localparam img_flags_t flags_idle = '{
                row_first: 1'b0,
                row_last:  1'b0,
                col_first: 1'b0,
                col_last:  1'b0,
                de:        1'b0
        };

endpackage

// ==== source/line_feeder.sv ====
// ------------------------------
// line feeder
// input stage, column counter and line rotation
// ------------------------------

`timescale 1ns/1ps

module line_feeder (
        input  logic                                 clk,
        input  logic                                 reset,
        input  logic                                 s_valid,
        input  pixel_pkg::img_flags_t                s_flags,
        input  pixel_pkg::pixel_t                    s_pixel,
        output logic [img_geom_pkg::line_count-1:0]  wr_en,
        output img_geom_pkg::col_addr_t              addr,
        output logic                                 a_valid,
        output pixel_pkg::img_flags_t                a_flags,
        output pixel_pkg::pixel_t                    a_pixel,
        output img_geom_pkg::line_sel_t              line_sel
);
        import img_geom_pkg::*;
        import pixel_pkg::*;

        // row start seen one cycle after the a_* stage
        logic sel_step;

        // ------------------------------
        // write side
        // ------------------------------
        always_ff @(posedge clk) begin
                if (reset) begin
                        wr_en                <= '0;
                        wr_en[line_count-1]  <= 1'b1;
                        addr                 <= '0;
                        a_valid              <= 1'b0;
                        a_flags              <= flags_idle;
                end else begin
                        if (s_valid && s_flags.col_first) begin
                                // next row goes to the next memory down
                                wr_en <= {wr_en[0], wr_en[line_count-1:1]};
                                addr  <= '0;
                        end else begin
                                addr <= addr + 1'b1;
                        end
                        a_valid <= s_valid;
                        a_flags <= s_valid ? s_flags : flags_idle;
                end
        end

        always_ff @(posedge clk) begin
                a_pixel <= s_pixel;
        end

        // ------------------------------
        // read side line select
        // ------------------------------
        // steps back once per row, two cycles behind the write rotation
        // so that it lines up with the registered memory output
        always_ff @(posedge clk) begin
                if (reset) begin
                        sel_step <= 1'b0;
                        line_sel <= '0;
                end else begin
                        sel_step <= a_flags.col_first;
                        if (sel_step) begin
                                if (line_sel == '0) begin
                                        line_sel <= line_sel_t'(line_count - 1);
                                end else begin
                                        line_sel <= line_sel - 1'b1;
                                end
                        end
                end
        end

        // exactly one memory takes each row
        wr_en_onehot: assert property (
                @(posedge clk) disable iff (reset)
                $onehot(wr_en)
        );

endmodule

// ==== source/line_store.sv ====
// ------------------------------
// line store
// read-first line memories with registered output,
// new pixel and flags delayed to match
// ------------------------------

`timescale 1ns/1ps

module line_store (
        input  logic                                 clk,
        input  logic                                 reset,
        input  logic [img_geom_pkg::line_count-1:0]  wr_en,
        input  img_geom_pkg::col_addr_t              addr,
        input  logic                                 a_valid,
        input  pixel_pkg::img_flags_t                a_flags,
        input  pixel_pkg::pixel_t                    a_pixel,
        output logic                                 b_valid,
        output pixel_pkg::img_flags_t                b_flags,
        output pixel_pkg::pixel_t                    b_pixel,
        output pixel_pkg::pixel_t                    b_lines [img_geom_pkg::line_count]
);
        import img_geom_pkg::*;
        import pixel_pkg::*;

        // first delay stage, same cycle as the memory read
        logic       d_valid;
        img_flags_t d_flags;
        pixel_t     d_pixel;

        logic [mem_addr_w-1:0] mem_addr;

        assign mem_addr = addr[mem_addr_w-1:0];

        // ------------------------------
        // line memories
        // ------------------------------
        for (genvar i = 0; i < line_count; i++) begin : g_line
                pixel_t mem [max_cols];
                pixel_t rd_q;

                // old word comes out while the new one goes in
                always_ff @(posedge clk) begin
                        if (a_valid && wr_en[i]) begin
                                mem[mem_addr] <= a_pixel;
                        end
                        rd_q <= mem[mem_addr];
                end

                // output register
                always_ff @(posedge clk) begin
                        b_lines[i] <= rd_q;
                end
        end

        // ------------------------------
        // pixel and flag delay
        // ------------------------------
        always_ff @(posedge clk) begin
                if (reset) begin
                        d_valid <= 1'b0;
                        d_flags <= flags_idle;
                        b_valid <= 1'b0;
                        b_flags <= flags_idle;
                end else begin
                        d_valid <= a_valid;
                        d_flags <= a_flags;
                        b_valid <= d_valid;
                        b_flags <= d_flags;
                end
        end

        always_ff @(posedge clk) begin
                d_pixel <= a_pixel;
                b_pixel <= d_pixel;
        end

        // a row longer than the memories would alias onto its own start
        addr_in_range: assert property (
                @(posedge clk) disable iff (reset)
                a_valid |-> (addr < col_addr_t'(max_cols))
        );

endmodule

// ==== source/window_border.sv ====
// ------------------------------
// window border
// orders the lines into a window and replicates
// the edge row at the top and bottom of a frame
// ------------------------------

`timescale 1ns/1ps

module window_border (
        input  logic                       clk,
        input  logic                       reset,
        input  logic                       b_valid,
        input  pixel_pkg::img_flags_t      b_flags,
        input  pixel_pkg::pixel_t          b_pixel,
        input  pixel_pkg::pixel_t          b_lines [img_geom_pkg::line_count],
        input  img_geom_pkg::line_sel_t    line_sel,
        output logic                       m_valid,
        output pixel_pkg::img_flags_t      m_flags,
        output pixel_pkg::window_t         m_window
);
        import img_geom_pkg::*;
        import pixel_pkg::*;

        // stage 1, raw window and per-row markers
        logic                s1_valid;
        logic                s1_col_first;
        logic                s1_col_last;
        logic [win_rows-1:0] s1_row_first;
        logic [win_rows-1:0] s1_row_last;
        logic [win_rows-1:0] s1_de;
        window_t             s1_window;

        // stage 2, edge positions
        logic                 s2_valid;
        img_flags_t           s2_flags;
        window_t              s2_window;
        logic [win_pos_w-1:0] s2_pos_first;
        logic [win_pos_w-1:0] s2_pos_last;

        logic [win_pos_w-1:0] pos_first;
        logic [win_pos_w-1:0] pos_last;

        // ------------------------------
        // stage 1
        // ------------------------------
        always_ff @(posedge clk) begin
                if (reset) begin
                        s1_valid     <= 1'b0;
                        s1_col_first <= 1'b0;
                        s1_col_last  <= 1'b0;
                        s1_row_first <= '0;
                        s1_row_last  <= '0;
                        s1_de        <= '0;
                end else begin
                        s1_valid     <= b_valid;
                        s1_col_first <= b_flags.col_first;
                        s1_col_last  <= b_flags.col_last;
                        // newest row follows the stream
                        if (b_valid) begin
                                s1_row_first[win_rows-1] <= b_flags.row_first;
                                s1_row_last[win_rows-1]  <= b_flags.row_last;
                                s1_de[win_rows-1]        <= b_flags.de;
                        end
                        // older rows age by one at each row start
                        if (b_flags.col_first) begin
                                for (int w = 0; w < win_rows - 1; w++) begin
                                        s1_row_first[w] <= s1_row_first[w+1];
                                        s1_row_last[w]  <= s1_row_last[w+1];
                                        s1_de[w]        <= s1_de[w+1];
                                end
                        end
                end
        end

        // memory i-1 after rotation holds the row i rows back
        always_ff @(posedge clk) begin
                s1_window[win_rows-1] <= b_pixel;
                for (int i = 1; i < win_rows; i++) begin
                        s1_window[win_rows-1-i] <= b_lines[(i - 1 + int'(line_sel)) % line_count];
                end
        end

        // ------------------------------
        // stage 2
        // ------------------------------
        // nearest frame start at or above the centre
        always_comb begin
                pos_first = '0;
                for (int w = 0; w <= win_center; w++) begin
                        if (s1_row_first[w]) begin
                                pos_first = win_pos_w'(w);
                        end
                end
        end

        // nearest frame end at or below the centre
        always_comb begin
                pos_last = win_pos_w'(win_rows - 1);
                for (int w = win_rows - 1; w >= win_center; w--) begin
                        if (s1_row_last[w]) begin
                                pos_last = win_pos_w'(w);
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        s2_valid <= 1'b0;
                        s2_flags <= flags_idle;
                end else begin
                        s2_valid           <= s1_valid;
                        s2_flags.row_first <= s1_row_first[win_center];
                        s2_flags.row_last  <= s1_row_last[win_center];
                        s2_flags.col_first <= s1_col_first;
                        s2_flags.col_last  <= s1_col_last;
                        s2_flags.de        <= s1_de[win_center];
                end
        end

        always_ff @(posedge clk) begin
                s2_window    <= s1_window;
                s2_pos_first <= pos_first;
                s2_pos_last  <= pos_last;
        end

        // ------------------------------
        // stage 3, replicate edge rows
        // ------------------------------
        always_ff @(posedge clk) begin
                if (reset) begin
                        m_valid <= 1'b0;
                        m_flags <= flags_idle;
                end else begin
                        m_valid <= s2_valid;
                        m_flags <= s2_flags;
                end
        end

        always_ff @(posedge clk) begin
                for (int w = 0; w < win_rows; w++) begin
                        if (win_pos_w'(w) < s2_pos_first) begin
                                m_window[w] <= s2_window[s2_pos_first];
                        end else if (win_pos_w'(w) > s2_pos_last) begin
                                m_window[w] <= s2_window[s2_pos_last];
                        end else begin
                                m_window[w] <= s2_window[w];
                        end
                end
        end

endmodule

// ==== source/img_window_top.sv ====
// ------------------------------
// image window top
// line buffer producing a 3-row vertical window
// ------------------------------

`timescale 1ns/1ps

module img_window_top (
        input  logic                   clk,
        input  logic                   reset,
        input  logic                   s_valid,
        input  pixel_pkg::img_flags_t  s_flags,
        input  pixel_pkg::pixel_t      s_pixel,
        output logic                   m_valid,
        output pixel_pkg::img_flags_t  m_flags,
        output pixel_pkg::window_t     m_window
);
        import img_geom_pkg::*;
        import pixel_pkg::*;

        // feeder to store
        logic [line_count-1:0] wr_en;
        col_addr_t             addr;
        logic                  a_valid;
        img_flags_t            a_flags;
        pixel_t                a_pixel;
        line_sel_t             line_sel;

        // store to border
        logic                  b_valid;
        img_flags_t            b_flags;
        pixel_t                b_pixel;
        pixel_t                b_lines [line_count];

        line_feeder u_line_feeder (
                .clk      (clk),
                .reset    (reset),
                .s_valid  (s_valid),
                .s_flags  (s_flags),
                .s_pixel  (s_pixel),
                .wr_en    (wr_en),
                .addr     (addr),
                .a_valid  (a_valid),
                .a_flags  (a_flags),
                .a_pixel  (a_pixel),
                .line_sel (line_sel)
        );

        line_store u_line_store (
                .clk     (clk),
                .reset   (reset),
                .wr_en   (wr_en),
                .addr    (addr),
                .a_valid (a_valid),
                .a_flags (a_flags),
                .a_pixel (a_pixel),
                .b_valid (b_valid),
                .b_flags (b_flags),
                .b_pixel (b_pixel),
                .b_lines (b_lines)
        );

        window_border u_window_border (
                .clk      (clk),
                .reset    (reset),
                .b_valid  (b_valid),
                .b_flags  (b_flags),
                .b_pixel  (b_pixel),
                .b_lines  (b_lines),
                .line_sel (line_sel),
                .m_valid  (m_valid),
                .m_flags  (m_flags),
                .m_window (m_window)
        );

endmodule

// ==== verification/img_window_cases.svh ====
// ------------------------------
// frame cases for the image window testbench
// geometry, pixel base and expected corner windows
// ------------------------------

`ifndef img_window_cases_svh
`define img_window_cases_svh

// columns: cols, rows, pixel base, top-left window, bottom-right window
// a window reads {row below, centre, row above} from the left
typedef struct packed {
        logic [7:0] cols;
        logic [7:0] rows;
        pixel_t     base;
        window_t    win_tl;
        window_t    win_br;
} frame_case_t;

localparam int num_cases = 6;

frame_case_t case_table [num_cases] = '{
        '{8'd8,  8'd4, 8'h10, 24'h201010, 24'h474737},
        // narrow frame right after a wider one
        '{8'd4,  8'd3, 8'h00, 24'h100000, 24'h232313},
        '{8'd16, 8'd5, 8'h80, 24'h908080, 24'hcfcfbf},
        // full width, two rows only
        '{8'd64, 8'd2, 8'h05, 24'h150505, 24'h545444},
        // pixel values wrap past 8'hff
        '{8'd3,  8'd6, 8'hf0, 24'h00f0f0, 24'h424232},
        '{8'd32, 8'd3, 8'h3c, 24'h4c3c3c, 24'h7b7b6b}
};

`endif

// ==== verification/img_window_tb.sv ====
// ------------------------------
// image window testbench
// raster frames in, window columns checked against a row clamp model
// ------------------------------

`timescale 1ns/1ps

module img_window_tb;
        import img_geom_pkg::*;
        import pixel_pkg::*;

        `include "img_window_cases.svh"

        localparam int latency      = 6;
        localparam int reset_cycles = 2;

        logic       clk = 1'b0;
        logic       reset;
        logic       s_valid;
        img_flags_t s_flags;
        pixel_t     s_pixel;
        logic       m_valid;
        img_flags_t m_flags;
        window_t    m_window;

        int seed    = 32'h68b6;
        int cycle   = 0;
        int limit   = 0;
        int checks  = 0;
        int errors  = 0;
        bit running = 1'b0;

        // expected output stream in raster order
        int         exp_cycle  [$];
        img_flags_t exp_flags  [$];
        window_t    exp_window [$];

        img_window_top u_img_window_top (
                .clk      (clk),
                .reset    (reset),
                .s_valid  (s_valid),
                .s_flags  (s_flags),
                .s_pixel  (s_pixel),
                .m_valid  (m_valid),
                .m_flags  (m_flags),
                .m_window (m_window)
        );

        initial begin
                forever #20 clk = ~clk;
        end

        always @(posedge clk) begin
                cycle++;
        end

        function automatic pixel_t pixel_at(pixel_t base, int r, int c);
                return pixel_t'(int'(base) + r * 16 + c);
        endfunction

        // rows outside the frame clamp to the nearest edge row
        function automatic window_t clamp_window(frame_case_t fc, int r, int c);
                window_t w;
                int      src;
                for (int k = 0; k < win_rows; k++) begin
                        src = r - win_center + k;
                        if (src < 0) begin
                                src = 0;
                        end else if (src > int'(fc.rows) - 1) begin
                                src = int'(fc.rows) - 1;
                        end
                        w[k] = pixel_at(fc.base, src, c);
                end
                return w;
        endfunction

        // output for input row r is centred on row r-1
        task automatic expect_output(frame_case_t fc, int r, int c, img_flags_t f);
                img_flags_t e;
                window_t    w;
                int         ctr;
                ctr         = r - 1;
                e.row_first = (ctr == 0);
                e.row_last  = (ctr == int'(fc.rows) - 1);
                e.col_first = f.col_first;
                e.col_last  = f.col_last;
                e.de        = (ctr >= 0);
                w = clamp_window(fc, ctr, c);
                if (ctr == 0 && c == 0) begin
                        w = fc.win_tl;
                end else if (ctr == int'(fc.rows) - 1 && c == int'(fc.cols) - 1) begin
                        w = fc.win_br;
                end
                exp_cycle.push_back(cycle + latency);
                exp_flags.push_back(e);
                exp_window.push_back(w);
        endtask

        task automatic idle(int n);
                repeat (n) begin
                        @(negedge clk);
                        s_valid = 1'b0;
                        s_flags = flags_idle;
                end
        endtask

        // extra row with de low pushes the last row out
        task automatic drive_frame(frame_case_t fc);
                img_flags_t f;
                for (int r = 0; r <= int'(fc.rows); r++) begin
                        for (int c = 0; c < int'(fc.cols); c++) begin
                                @(negedge clk);
                                f.row_first = (r == 0);
                                f.row_last  = (r == int'(fc.rows) - 1);
                                f.col_first = (c == 0);
                                f.col_last  = (c == int'(fc.cols) - 1);
                                f.de        = (r < int'(fc.rows));
                                s_valid = 1'b1;
                                s_flags = f;
                                s_pixel = pixel_at(fc.base, r, c);
                                expect_output(fc, r, c, f);
                        end
                end
        endtask

        task automatic check_idle_outputs();
                checks++;
                assert (!m_valid && m_flags == flags_idle) else begin
                        errors++;
                        $display("error m_valid expected %h got %h, m_flags expected %h got %h",
                                 1'b0, m_valid, flags_idle, m_flags);
                end
        endtask

        task automatic check_output();
                img_flags_t e;
                window_t    w;
                e = exp_flags.pop_front();
                w = exp_window.pop_front();
                exp_cycle.delete(0);
                checks++;
                assert (m_valid) else begin
                        errors++;
                        $display("missing output, m_valid low at cycle %0d", cycle);
                end
                assert (m_flags == e) else begin
                        errors++;
                        $display("error m_flags expected %h got %h", e, m_flags);
                end
                if (e.de) begin
                        assert (m_window == w) else begin
                                errors++;
                                $display("error m_window expected %h got %h", w, m_window);
                        end
                end
        endtask

        // ------------------------------
        // output checker
        // ------------------------------
        always @(negedge clk) begin
                if (running) begin
                        if (exp_cycle.size() != 0 && exp_cycle[0] == cycle) begin
                                check_output();
                        end else begin
                                checks++;
                                assert (!m_valid) else begin
                                        errors++;
                                        $display("unexpected output at cycle %0d", cycle);
                                end
                        end
                end
        end

        initial begin
                wait (limit != 0);
                while (cycle <= limit) begin
                        @(posedge clk);
                end
                $display("timeout, outputs still pending after %0d cycles", limit);
                $display("Done: errors found");
                $finish;
        end

        // ------------------------------
        // stimulus
        // ------------------------------
        initial begin
                int gaps [num_cases];
                int total;
                reset   = 1'b1;
                s_valid = 1'b0;
                s_flags = flags_idle;
                s_pixel = '0;
                total   = reset_cycles + 20;
                for (int i = 0; i < num_cases; i++) begin
                        gaps[i] = $random(seed) & 7;
                        total += (int'(case_table[i].rows) + 1) * int'(case_table[i].cols);
                        total += gaps[i];
                end
                limit = total;
                repeat (reset_cycles) begin
                        @(negedge clk);
                        check_idle_outputs();
                end
                reset = 1'b0;
                @(negedge clk);
                check_idle_outputs();
                running = 1'b1;
                for (int i = 0; i < num_cases; i++) begin
                        idle(gaps[i]);
                        drive_frame(case_table[i]);
                end
                idle(1);
                while (exp_cycle.size() != 0) begin
                        @(negedge clk);
                end
                $display("checks %0d, errors %0d", checks, errors);
                if (errors == 0) begin
                        $display("Done: no errors");
                end else begin
                        $display("Done: errors found");
                end
                $finish;
        end

endmodule

// ==== img_window_top.f ====
+incdir+verification
source/img_geom_pkg.sv
source/pixel_pkg.sv
source/line_feeder.sv
source/line_store.sv
source/window_border.sv
source/img_window_top.sv
verification/img_window_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the image window testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
        -f img_window_top.f \
        --top-module img_window_tb \
        -o img_window_sim

./obj_dir/img_window_sim > sim.log 2>&1
cat sim.log

if grep -q "Done: errors found" sim.log; then
        echo "simulation failed"
        exit 1
fi
echo "simulation passed"
